// ==== cache_top.f ====
src/cache_param_pkg.sv
src/cache_types_pkg.sv
src/tag_array.sv
src/data_array.sv
src/cache_pipe.sv
src/cache_top.sv
bench/cache_tb.sv

// ==== Makefile ====
# Verilator build and run of the cache lookup testbench

SRCS := $(wildcard src/*.sv) bench/cache_tb.sv

.PHONY: all run clean

all: run

obj_dir/Vcache_tb: $(SRCS) cache_top.f
	verilator --binary --timing --timescale 1ns/1ps --top-module cache_tb \
		-f cache_top.f -Mdir obj_dir -o Vcache_tb

run: obj_dir/Vcache_tb
	./obj_dir/Vcache_tb | tee sim.log
	@if grep -q "Finished with errors" sim.log; then exit 1; fi
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/cache_tb.sv ====
//==========================================================================
// Cache lookup testbench
// Random lookups from a fixed seed, checked against a reference cache
// model, one line per test and a closing summary
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_tb
  import cache_param_pkg::*;
  import cache_types_pkg::*;
();

  // DUT ports
  logic                   clk;
  logic                   rst;
  logic                   lu_valid;
  t_lu_op                 lu_op;
  logic [ADDR_WIDTH-1:0]  lu_address;
  logic [TQ_ID_WIDTH-1:0] lu_tq_id;
  logic [WORD_WIDTH-1:0]  lu_data;
  logic [CL_WIDTH-1:0]    lu_cl_data;
  logic                   rsp_valid;
  t_lu_op                 rsp_op;
  t_lu_result             rsp_result;
  logic [TQ_ID_WIDTH-1:0] rsp_tq_id;
  logic [ADDR_WIDTH-1:0]  rsp_address;
  logic [CL_WIDTH-1:0]    rsp_data;
  logic                   fm_valid;
  t_fm_op                 fm_op;
  logic [ADDR_WIDTH-1:0]  fm_address;
  logic [TQ_ID_WIDTH-1:0] fm_tq_id;
  logic [CL_WIDTH-1:0]    fm_data;

  // Expected outputs of one lookup, due at a fixed cycle
  typedef struct {
    int unsigned            due;
    t_lu_op                 op;
    t_lu_result             result;
    logic [TQ_ID_WIDTH-1:0] tq_id;
    logic [ADDR_WIDTH-1:0]  address;
    logic [CL_WIDTH-1:0]    data;
    logic                   fm_valid;
    t_fm_op                 fm_op;
    logic [ADDR_WIDTH-1:0]  fm_address;
    logic [CL_WIDTH-1:0]    fm_data;
  } t_expect;

  t_expect exp_q[$];

  // Reference model of the cache state
  logic [TAG_WIDTH-1:0] m_tag  [NUM_SETS][NUM_WAYS];
  logic [CL_WIDTH-1:0]  m_line [NUM_SETS][NUM_WAYS];
  logic [NUM_WAYS-1:0]  m_valid [NUM_SETS];
  logic [NUM_WAYS-1:0]  m_mru   [NUM_SETS];
  logic [NUM_WAYS-1:0]  m_mod   [NUM_SETS];

  // Bookkeeping
  logic [31:0] rng;
  int unsigned cyc;
  int          mon_errors;
  int          run_errors;
  int          checks;
  int          evicts_seen;
  int          tests_passed;
  int          tests_failed;
  logic        aborted;

  cache_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Free-running cycle count, used for the latency check
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  //========================================================================
  // Random numbers and the reference model
  //========================================================================
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [CL_WIDTH-1:0] rand_line();
    return {next_rand(), next_rand(), next_rand(), next_rand()};
  endfunction

  // Low four bits carry word offset and byte bits
  function automatic logic [ADDR_WIDTH-1:0] make_addr(input logic [TAG_WIDTH-1:0] tag,
                                                      input logic [SET_WIDTH-1:0] si,
                                                      input logic [3:0] low);
    return {tag, si, low};
  endfunction

  // Touched way becomes MRU, a full MRU vector collapses to that way
  function automatic void mark_mru(input logic [SET_WIDTH-1:0] si, input int way);
    m_mru[si][way] = 1'b1;
    if (&m_mru[si]) begin
      m_mru[si]      = '0;
      m_mru[si][way] = 1'b1;
    end
  endfunction

  // Lowest invalid way first, else lowest way not marked MRU
  function automatic int pick_victim(input logic [SET_WIDTH-1:0] si);
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!m_valid[si][w]) return w;
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!m_mru[si][w]) return w;
    end
    return 0;
  endfunction

  // Apply one lookup to the model and queue what the DUT must answer
  task automatic model_lookup(input t_lu_op op, input logic [ADDR_WIDTH-1:0] addr,
                              input logic [TQ_ID_WIDTH-1:0] id,
                              input logic [WORD_WIDTH-1:0] word,
                              input logic [CL_WIDTH-1:0] line);
    t_expect                 e;
    logic [SET_WIDTH-1:0]    si;
    logic [TAG_WIDTH-1:0]    tag;
    logic [OFFSET_WIDTH-1:0] off;
    int                      hit_way;
    int                      way;
    si  = addr[MSB_SET:LSB_SET];
    tag = addr[MSB_TAG:LSB_TAG];
    off = addr[MSB_OFFSET:LSB_OFFSET];
    hit_way = -1;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (m_valid[si][w] && (m_tag[si][w] == tag)) hit_way = w;
    end
    // Driven at this edge, so q1 is the next cycle and q3 two cycles later
    e.due        = cyc + 3;
    e.op         = op;
    e.tq_id      = id;
    e.address    = {addr[ADDR_WIDTH-1:LSB_OFFSET], 2'b00};
    e.data       = '0;
    e.fm_valid   = 1'b0;
    e.fm_op      = FM_NONE;
    e.fm_address = '0;
    e.fm_data    = '0;
    if (op == FILL_LU) begin
      e.result = NO_RSP;
      e.data   = line;
      way = (hit_way >= 0) ? hit_way : pick_victim(si);
      // Modified victim goes back to far memory first
      if (m_valid[si][way] && m_mod[si][way]) begin
        e.fm_valid   = 1'b1;
        e.fm_op      = DIRTY_EVICT_OP;
        e.fm_address = {m_tag[si][way], si, 4'h0};
        e.fm_data    = m_line[si][way];
      end
      m_tag[si][way]   = tag;
      m_line[si][way]  = line;
      m_valid[si][way] = 1'b1;
      m_mod[si][way]   = 1'b0;
      mark_mru(si, way);
    end else if (hit_way >= 0) begin
      e.result = HIT;
      if (op == RD_LU) begin
        e.data = m_line[si][hit_way];
      end else begin
        m_line[si][hit_way][int'(off)*WORD_WIDTH +: WORD_WIDTH] = word;
        m_mod[si][hit_way] = 1'b1;
      end
      mark_mru(si, hit_way);
    end else begin
      e.result     = MISS;
      e.fm_valid   = 1'b1;
      e.fm_op      = FILL_REQ_OP;
      e.fm_address = e.address;
    end
    exp_q.push_back(e);
  endtask

  //========================================================================
  // Stimulus and response checking
  //========================================================================
  task automatic issue(input t_lu_op op, input logic [ADDR_WIDTH-1:0] addr,
                       input logic [WORD_WIDTH-1:0] word,
                       input logic [CL_WIDTH-1:0] line);
    logic [31:0] r;
    r = next_rand();
    @(posedge clk);
    lu_valid   <= 1'b1;
    lu_op      <= op;
    lu_address <= addr;
    lu_tq_id   <= r[TQ_ID_WIDTH-1:0];
    lu_data    <= word;
    lu_cl_data <= line;
    model_lookup(op, addr, r[TQ_ID_WIDTH-1:0], word, line);
  endtask

  task automatic go_idle();
    @(posedge clk);
    lu_valid <= 1'b0;
  endtask

  // Wait for every queued response, bounded
  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_q.size() != 0) && (n < 50)) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout waiting for rsp_valid, %0d responses never arrived", exp_q.size());
      run_errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic expect_eq(input string name, input logic [CL_WIDTH-1:0] want,
                           input logic [CL_WIDTH-1:0] got);
    checks++;
    if (got !== want) begin
      $display("FAIL %s expected %h got %h", name, want, got);
      mon_errors++;
    end
  endtask

  task automatic check_response();
    t_expect e;
    if (exp_q.size() == 0) begin
      $display("Response for tq_id %h arrived with no lookup outstanding", rsp_tq_id);
      mon_errors++;
    end else begin
      e = exp_q.pop_front();
      if (cyc != e.due) begin
        $display("Response for tq_id %h came at cycle %0d instead of %0d",
                 rsp_tq_id, cyc, e.due);
        mon_errors++;
      end
      expect_eq("rsp_op", CL_WIDTH'(e.op), CL_WIDTH'(rsp_op));
      expect_eq("rsp_result", CL_WIDTH'(e.result), CL_WIDTH'(rsp_result));
      expect_eq("rsp_tq_id", CL_WIDTH'(e.tq_id), CL_WIDTH'(rsp_tq_id));
      expect_eq("rsp_address", CL_WIDTH'(e.address), CL_WIDTH'(rsp_address));
      expect_eq("rsp_data", e.data, rsp_data);
      expect_eq("fm_valid", CL_WIDTH'(e.fm_valid), CL_WIDTH'(fm_valid));
      if (e.fm_valid && fm_valid) begin
        expect_eq("fm_op", CL_WIDTH'(e.fm_op), CL_WIDTH'(fm_op));
        expect_eq("fm_address", CL_WIDTH'(e.fm_address), CL_WIDTH'(fm_address));
        expect_eq("fm_tq_id", CL_WIDTH'(e.tq_id), CL_WIDTH'(fm_tq_id));
        expect_eq("fm_data", e.fm_data, fm_data);
      end
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!rst && rsp_valid) begin
      check_response();
      if (fm_valid && (fm_op == DIRTY_EVICT_OP)) evicts_seen++;
    end else if (!rst && fm_valid) begin
      $display("fm_valid raised without a response in the same cycle");
      mon_errors++;
    end
  end

  task automatic report_test(input int num, input string name, input int err_before);
    if ((mon_errors + run_errors) == err_before) begin
      $display("Test %0d %s: passed", num, name);
      tests_passed++;
    end else begin
      $display("Test %0d %s: failed, %0d new errors", num, name,
               mon_errors + run_errors - err_before);
      tests_failed++;
    end
  endtask

  //========================================================================
  // Tests
  //========================================================================
  task automatic cold_misses();
    int e0;
    e0 = mon_errors + run_errors;
    issue(RD_LU, next_rand(), '0, '0);
    go_idle();
    issue(WR_LU, next_rand(), next_rand(), '0);
    go_idle();
    wait_drain();
    report_test(1, "cold misses", e0);
  endtask

  task automatic fill_then_read(input logic [ADDR_WIDTH-1:0] a);
    int          e0;
    logic [31:0] r;
    e0 = mon_errors + run_errors;
    issue(FILL_LU, a, '0, rand_line());
    go_idle();
    r = next_rand();
    issue(RD_LU, {a[ADDR_WIDTH-1:4], r[3:0]}, '0, '0);
    go_idle();
    wait_drain();
    report_test(2, "fill then read", e0);
  endtask

  task automatic write_hit_merge(input logic [ADDR_WIDTH-1:0] a);
    int          e0;
    logic [31:0] r;
    e0 = mon_errors + run_errors;
    r = next_rand();
    issue(WR_LU, {a[ADDR_WIDTH-1:4], r[3:0]}, next_rand(), '0);
    go_idle();
    issue(RD_LU, a, '0, '0);
    go_idle();
    wait_drain();
    report_test(3, "write hit merge", e0);
  endtask

  // Five tags in one set, the first one dirty and evicted by the fifth
  task automatic replacement_evict(input logic [SET_WIDTH-1:0] si);
    int                   e0;
    int                   ev0;
    logic [31:0]          r;
    logic [TAG_WIDTH-1:0] tags [5];
    e0  = mon_errors + run_errors;
    ev0 = evicts_seen;
    for (int i = 0; i < 5; i++) begin
      r = next_rand();
      tags[i] = {r[TAG_WIDTH-1:3], 3'(i)};
    end
    issue(FILL_LU, make_addr(tags[0], si, 4'h0), '0, rand_line());
    go_idle();
    r = next_rand();
    issue(WR_LU, make_addr(tags[0], si, r[3:0]), next_rand(), '0);
    go_idle();
    for (int i = 1; i < 5; i++) begin
      issue(FILL_LU, make_addr(tags[i], si, 4'h0), '0, rand_line());
      go_idle();
    end
    issue(RD_LU, make_addr(tags[0], si, 4'h8), '0, '0);
    go_idle();
    wait_drain();
    if (!aborted && (evicts_seen == ev0)) begin
      $display("No dirty evict seen when the modified way was replaced");
      run_errors++;
    end
    report_test(4, "replacement and dirty evict", e0);
  endtask

  // One lookup per cycle over 2 sets and 6 tags
  task automatic random_stream();
    int                   e0;
    int                   ti;
    logic [31:0]          r;
    logic [SET_WIDTH-1:0] s0;
    logic [TAG_WIDTH-1:0] tags [6];
    t_lu_op               op;
    e0 = mon_errors + run_errors;
    r  = next_rand();
    s0 = r[SET_WIDTH-1:0];
    for (int i = 0; i < 6; i++) begin
      r = next_rand();
      tags[i] = {r[TAG_WIDTH-1:3], 3'(i)};
    end
    for (int n = 0; n < 400; n++) begin
      r  = next_rand();
      op = (r[1:0] == 2'd2) ? FILL_LU : (r[0] ? WR_LU : RD_LU);
      ti = int'(r[7:4]) % 6;
      issue(op, make_addr(tags[ti], r[8] ? (s0 ^ 4'h8) : s0, r[15:12]),
            next_rand(), rand_line());
    end
    go_idle();
    wait_drain();
    report_test(5, "back-to-back random stream", e0);
  endtask

  //========================================================================
  // Main sequence
  //========================================================================
  initial begin
    logic [ADDR_WIDTH-1:0] fill_addr;
    rst          <= 1'b1;
    lu_valid     <= 1'b0;
    lu_op        <= RD_LU;
    lu_address   <= '0;
    lu_tq_id     <= '0;
    lu_data      <= '0;
    lu_cl_data   <= '0;
    cyc          <= 0;
    rng          = 32'd24292;
    mon_errors   = 0;
    run_errors   = 0;
    checks       = 0;
    evicts_seen  = 0;
    tests_passed = 0;
    tests_failed = 0;
    aborted      = 1'b0;
    for (int s = 0; s < NUM_SETS; s++) begin
      m_valid[s] = '0;
      m_mru[s]   = '0;
      m_mod[s]   = '0;
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    fill_addr = next_rand();
    if (!aborted) cold_misses();
    if (!aborted) fill_then_read(fill_addr);
    if (!aborted) write_hit_merge(fill_addr);
    if (!aborted) replacement_evict(fill_addr[MSB_SET:LSB_SET] + 4'd1);
    if (!aborted) random_stream();

    $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, checks, mon_errors + run_errors);
    if ((mon_errors + run_errors) == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/cache_top.sv ====
//==========================================================================
// Cache top level
// Lookup pipeline joined to its tag array and data array
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_top
  import cache_param_pkg::*;
  import cache_types_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  // Lookup request
  input  logic                   lu_valid,
  input  t_lu_op                 lu_op,
  input  logic [ADDR_WIDTH-1:0]  lu_address,
  input  logic [TQ_ID_WIDTH-1:0] lu_tq_id,
  input  logic [WORD_WIDTH-1:0]  lu_data,
  input  logic [CL_WIDTH-1:0]    lu_cl_data,
  // Lookup response
  output logic                   rsp_valid,
  output t_lu_op                 rsp_op,
  output t_lu_result             rsp_result,
  output logic [TQ_ID_WIDTH-1:0] rsp_tq_id,
  output logic [ADDR_WIDTH-1:0]  rsp_address,
  output logic [CL_WIDTH-1:0]    rsp_data,
  // Far-memory request
  output logic                   fm_valid,
  output t_fm_op                 fm_op,
  output logic [ADDR_WIDTH-1:0]  fm_address,
  output logic [TQ_ID_WIDTH-1:0] fm_tq_id,
  output logic [CL_WIDTH-1:0]    fm_data
);

  // Tag array read and set rewrite
  logic [SET_WIDTH-1:0]               tag_rd_set;
  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tag_rd_tags;
  logic [NUM_WAYS-1:0]                tag_rd_valid;
  logic [NUM_WAYS-1:0]                tag_rd_mru;
  logic [NUM_WAYS-1:0]                tag_rd_modified;
  logic                               tag_wr_en;
  logic [SET_WIDTH-1:0]               tag_wr_set;
  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tag_wr_tags;
  logic [NUM_WAYS-1:0]                tag_wr_valid;
  logic [NUM_WAYS-1:0]                tag_wr_mru;
  logic [NUM_WAYS-1:0]                tag_wr_modified;

  // Data array read and line write
  logic [CL_ADDR_WIDTH-1:0]           cl_rd_address;
  logic [CL_WIDTH-1:0]                cl_rd_data;
  logic                               cl_wr_en;
  logic [CL_ADDR_WIDTH-1:0]           cl_wr_address;
  logic [CL_WIDTH-1:0]                cl_wr_data;

  // Port names match the top ports and the wires above
  cache_pipe u_cache_pipe (.*);

  tag_array u_tag_array (
    .clk         (clk),
    .rst         (rst),
    .rd_set      (tag_rd_set),
    .rd_tags     (tag_rd_tags),
    .rd_valid    (tag_rd_valid),
    .rd_mru      (tag_rd_mru),
    .rd_modified (tag_rd_modified),
    .wr_en       (tag_wr_en),
    .wr_set      (tag_wr_set),
    .wr_tags     (tag_wr_tags),
    .wr_valid    (tag_wr_valid),
    .wr_mru      (tag_wr_mru),
    .wr_modified (tag_wr_modified)
  );

  data_array u_data_array (
    .clk        (clk),
    .rd_address (cl_rd_address),
    .rd_data    (cl_rd_data),
    .wr_en      (cl_wr_en),
    .wr_address (cl_wr_address),
    .wr_data    (cl_wr_data)
  );

endmodule

`default_nettype wire

// ==== src/cache_pipe.sv ====
//==========================================================================
// Cache lookup pipeline
// q1 issues the tag read, q2 compares tags, picks a victim and updates
// the set, q3 merges data and drives the response and far-memory request
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module cache_pipe
  import cache_param_pkg::*;
  import cache_types_pkg::*;
(
  input  logic                               clk,
  input  logic                               rst,
  // Lookup request at q1
  input  logic                               lu_valid,
  input  t_lu_op                             lu_op,
  input  logic [ADDR_WIDTH-1:0]              lu_address,
  input  logic [TQ_ID_WIDTH-1:0]             lu_tq_id,
  input  logic [WORD_WIDTH-1:0]              lu_data,
  input  logic [CL_WIDTH-1:0]                lu_cl_data,
  // Lookup response at q3
  output logic                               rsp_valid,
  output t_lu_op                             rsp_op,
  output t_lu_result                         rsp_result,
  output logic [TQ_ID_WIDTH-1:0]             rsp_tq_id,
  output logic [ADDR_WIDTH-1:0]              rsp_address,
  output logic [CL_WIDTH-1:0]                rsp_data,
  // Far-memory request at q3
  output logic                               fm_valid,
  output t_fm_op                             fm_op,
  output logic [ADDR_WIDTH-1:0]              fm_address,
  output logic [TQ_ID_WIDTH-1:0]             fm_tq_id,
  output logic [CL_WIDTH-1:0]                fm_data,
  // Tag array
  output logic [SET_WIDTH-1:0]               tag_rd_set,
  input  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tag_rd_tags,
  input  logic [NUM_WAYS-1:0]                tag_rd_valid,
  input  logic [NUM_WAYS-1:0]                tag_rd_mru,
  input  logic [NUM_WAYS-1:0]                tag_rd_modified,
  output logic                               tag_wr_en,
  output logic [SET_WIDTH-1:0]               tag_wr_set,
  output logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tag_wr_tags,
  output logic [NUM_WAYS-1:0]                tag_wr_valid,
  output logic [NUM_WAYS-1:0]                tag_wr_mru,
  output logic [NUM_WAYS-1:0]                tag_wr_modified,
  // Data array
  output logic [CL_ADDR_WIDTH-1:0]           cl_rd_address,
  input  logic [CL_WIDTH-1:0]                cl_rd_data,
  output logic                               cl_wr_en,
  output logic [CL_ADDR_WIDTH-1:0]           cl_wr_address,
  output logic [CL_WIDTH-1:0]                cl_wr_data
);

  // q2 stage register
  logic                    valid_q2;
  t_lu_op                  op_q2;
  logic [TQ_ID_WIDTH-1:0]  tq_id_q2;
  logic [OFFSET_WIDTH-1:0] offset_q2;
  logic [SET_WIDTH-1:0]    set_q2;
  logic [TAG_WIDTH-1:0]    tag_q2;
  logic [WORD_WIDTH-1:0]   data_q2;
  logic [CL_WIDTH-1:0]     cl_data_q2;

  // q2 lookup results
  logic [NUM_WAYS-1:0]     way_hit_q2;
  logic                    hit_q2;
  logic [WAY_WIDTH-1:0]    hit_way_q2;
  logic [WAY_WIDTH-1:0]    inv_way_q2;
  logic [WAY_WIDTH-1:0]    lru_way_q2;
  logic [WAY_WIDTH-1:0]    way_q2;
  logic                    is_fill_q2;
  logic                    dirty_evict_q2;

  // q3 stage register
  logic                    valid_q3;
  t_lu_op                  op_q3;
  logic [TQ_ID_WIDTH-1:0]  tq_id_q3;
  logic [OFFSET_WIDTH-1:0] offset_q3;
  logic [SET_WIDTH-1:0]    set_q3;
  logic [TAG_WIDTH-1:0]    tag_q3;
  logic [WORD_WIDTH-1:0]   data_q3;
  logic [CL_WIDTH-1:0]     cl_data_q3;
  logic                    hit_q3;
  logic [WAY_WIDTH-1:0]    way_q3;
  logic                    dirty_evict_q3;
  logic [TAG_WIDTH-1:0]    victim_tag_q3;

  // q3 decode
  logic                    is_fill_q3;
  logic                    rd_hit_q3;
  logic                    wr_hit_q3;
  logic [CL_WIDTH-1:0]     merged_q3;

  //========================================================================
  // q1 : address split and tag read
  //========================================================================
  assign tag_rd_set = lu_address[MSB_SET:LSB_SET];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q2 <= 1'b0;
    end else begin
      valid_q2 <= lu_valid;
    end
  end

  always_ff @(posedge clk) begin
    op_q2      <= lu_op;
    tq_id_q2   <= lu_tq_id;
    offset_q2  <= lu_address[MSB_OFFSET:LSB_OFFSET];
    set_q2     <= lu_address[MSB_SET:LSB_SET];
    tag_q2     <= lu_address[MSB_TAG:LSB_TAG];
    data_q2    <= lu_data;
    cl_data_q2 <= lu_cl_data;
  end

  //========================================================================
  // q2 : tag compare, victim, set update, data read
  //========================================================================
  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit_q2[w] = valid_q2 && tag_rd_valid[w] && (tag_rd_tags[w] == tag_q2);
    end
  end

  assign hit_q2     = |way_hit_q2;
  assign is_fill_q2 = (op_q2 == FILL_LU);

  // Lowest matching, lowest invalid and lowest non-MRU ways
  always_comb begin
    hit_way_q2 = '0;
    inv_way_q2 = '0;
    lru_way_q2 = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (way_hit_q2[w]) begin
        hit_way_q2 = WAY_WIDTH'(w);
      end
      if (!tag_rd_valid[w]) begin
        inv_way_q2 = WAY_WIDTH'(w);
      end
      if (!tag_rd_mru[w]) begin
        lru_way_q2 = WAY_WIDTH'(w);
      end
    end
  end

  // Hit way, or victim for a fill that misses
  assign way_q2 = hit_q2        ? hit_way_q2 :
                  &tag_rd_valid ? lru_way_q2 :
                                  inv_way_q2;

  // Fill replacing a modified line pushes it out to far memory
  assign dirty_evict_q2 = valid_q2 && is_fill_q2 &&
                          tag_rd_valid[way_q2] && tag_rd_modified[way_q2];

  // New contents of the whole set
  always_comb begin
    tag_wr_en       = valid_q2 && (hit_q2 || is_fill_q2);
    tag_wr_set      = set_q2;
    tag_wr_tags     = tag_rd_tags;
    tag_wr_valid    = tag_rd_valid;
    tag_wr_modified = tag_rd_modified;
    // MRU set on the touched way, others cleared once all would be set
    tag_wr_mru         = tag_rd_mru;
    tag_wr_mru[way_q2] = 1'b1;
    if (&tag_wr_mru) begin
      tag_wr_mru         = '0;
      tag_wr_mru[way_q2] = 1'b1;
    end
    if (is_fill_q2) begin
      tag_wr_tags[way_q2]     = tag_q2;
      tag_wr_valid[way_q2]    = 1'b1;
      tag_wr_modified[way_q2] = 1'b0;
    end else if ((op_q2 == WR_LU) && hit_q2) begin
      tag_wr_modified[way_q2] = 1'b1;
    end
  end

  // Old line of the touched way comes back at q3
  assign cl_rd_address = {set_q2, way_q2};

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q3 <= 1'b0;
    end else begin
      valid_q3 <= valid_q2;
    end
  end

  always_ff @(posedge clk) begin
    op_q3          <= op_q2;
    tq_id_q3       <= tq_id_q2;
    offset_q3      <= offset_q2;
    set_q3         <= set_q2;
    tag_q3         <= tag_q2;
    data_q3        <= data_q2;
    cl_data_q3     <= cl_data_q2;
    hit_q3         <= hit_q2;
    way_q3         <= way_q2;
    dirty_evict_q3 <= dirty_evict_q2;
    victim_tag_q3  <= tag_rd_tags[way_q2];
  end

  //========================================================================
  // q3 : response, line write, far-memory request
  //========================================================================
  assign is_fill_q3 = (op_q3 == FILL_LU);
  assign rd_hit_q3  = hit_q3 && (op_q3 == RD_LU);
  assign wr_hit_q3  = hit_q3 && (op_q3 == WR_LU);

  assign rsp_valid   = valid_q3;
  assign rsp_op      = op_q3;
  assign rsp_tq_id   = tq_id_q3;
  assign rsp_result  = is_fill_q3 ? NO_RSP :
                       hit_q3     ? HIT    :
                                    MISS;
  assign rsp_address = {tag_q3, set_q3, offset_q3, {LSB_OFFSET{1'b0}}};
  assign rsp_data    = is_fill_q3 ? cl_data_q3 :
                       rd_hit_q3  ? cl_rd_data :
                                    '0;

  // Current line with the addressed word replaced
  always_comb begin
    merged_q3 = cl_rd_data;
    merged_q3[offset_q3*WORD_WIDTH +: WORD_WIDTH] = data_q3;
  end

  assign cl_wr_en      = valid_q3 && (is_fill_q3 || wr_hit_q3);
  assign cl_wr_address = {set_q3, way_q3};
  assign cl_wr_data    = is_fill_q3 ? cl_data_q3 : merged_q3;

  // Miss asks for the line, dirty victim goes back with its own address
  always_comb begin
    fm_valid   = 1'b0;
    fm_op      = FM_NONE;
    fm_address = '0;
    fm_tq_id   = tq_id_q3;
    fm_data    = '0;
    if (valid_q3 && !is_fill_q3 && !hit_q3) begin
      fm_valid   = 1'b1;
      fm_op      = FILL_REQ_OP;
      fm_address = rsp_address;
    end else if (dirty_evict_q3) begin
      fm_valid   = 1'b1;
      fm_op      = DIRTY_EVICT_OP;
      fm_address = {victim_tag_q3, set_q3, {(OFFSET_WIDTH + LSB_OFFSET){1'b0}}};
      fm_data    = cl_rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== src/data_array.sv ====
//==========================================================================
// Data array
// Cache-line storage addressed by {set, way}
// Registered read, same-cycle write to the read address is forwarded
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module data_array
  import cache_param_pkg::*;
(
  input  logic                     clk,
  // Read port with one cycle latency
  input  logic [CL_ADDR_WIDTH-1:0] rd_address,
  output logic [CL_WIDTH-1:0]      rd_data,
  // Write port, one whole line
  input  logic                     wr_en,
  input  logic [CL_ADDR_WIDTH-1:0] wr_address,
  input  logic [CL_WIDTH-1:0]      wr_data
);

  // One entry per way of every set
  logic [CL_WIDTH-1:0] cl_mem [NUM_SETS*NUM_WAYS];

  logic fwd;

  assign fwd = wr_en && (wr_address == rd_address);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      cl_mem[wr_address] <= wr_data;
    end
  end

  // Line being written this cycle bypasses the storage
  always_ff @(posedge clk) begin
    if (fwd) begin
      rd_data <= wr_data;
    end else begin
      rd_data <= cl_mem[rd_address];
    end
  end

endmodule

`default_nettype wire

// ==== src/tag_array.sv ====
//==========================================================================
// Tag array
// Per-set tags with valid, MRU and modified bits for every way
// Registered read, whole-set write, same-cycle write forwarded to the read
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module tag_array
  import cache_param_pkg::*;
(
  input  logic                               clk,
  input  logic                               rst,
  // Read port with one cycle latency
  input  logic [SET_WIDTH-1:0]               rd_set,
  output logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] rd_tags,
  output logic [NUM_WAYS-1:0]                rd_valid,
  output logic [NUM_WAYS-1:0]                rd_mru,
  output logic [NUM_WAYS-1:0]                rd_modified,
  // Write port rewriting one whole set
  input  logic                               wr_en,
  input  logic [SET_WIDTH-1:0]               wr_set,
  input  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] wr_tags,
  input  logic [NUM_WAYS-1:0]                wr_valid,
  input  logic [NUM_WAYS-1:0]                wr_mru,
  input  logic [NUM_WAYS-1:0]                wr_modified
);

  // Storage
  logic [NUM_WAYS-1:0][TAG_WIDTH-1:0] tag_mem   [NUM_SETS];
  logic [NUM_WAYS-1:0]                valid_mem [NUM_SETS];
  logic [NUM_WAYS-1:0]                mru_mem   [NUM_SETS];
  logic [NUM_WAYS-1:0]                mod_mem   [NUM_SETS];

  // Write and read hit the same set in this cycle
  logic fwd;

  assign fwd = wr_en && (wr_set == rd_set);

  // Tags
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_set] <= wr_tags;
    end
  end

  // State bits, all cleared by reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_mem[s] <= '0;
        mru_mem[s]   <= '0;
        mod_mem[s]   <= '0;
      end
    end else if (wr_en) begin
      valid_mem[wr_set] <= wr_valid;
      mru_mem[wr_set]   <= wr_mru;
      mod_mem[wr_set]   <= wr_modified;
    end
  end

  //========================================================================
  // Read register
  //========================================================================
  // New set contents win over storage when both touch rd_set
  always_ff @(posedge clk) begin
    rd_tags <= fwd ? wr_tags : tag_mem[rd_set];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid    <= '0;
      rd_mru      <= '0;
      rd_modified <= '0;
    end else if (fwd) begin
      rd_valid    <= wr_valid;
      rd_mru      <= wr_mru;
      rd_modified <= wr_modified;
    end else begin
      rd_valid    <= valid_mem[rd_set];
      rd_mru      <= mru_mem[rd_set];
      rd_modified <= mod_mem[rd_set];
    end
  end

endmodule

`default_nettype wire

// ==== src/cache_types_pkg.sv ====
//==========================================================================
// Cache opcode and result types
// Lookup opcodes, lookup results and far-memory request opcodes
//==========================================================================
`default_nettype none

package cache_types_pkg;

  // Lookup opcodes coming from the transaction queue
  typedef enum logic [1:0] {
    RD_LU,
    WR_LU,
    FILL_LU
  } t_lu_op;

  // Lookup result, fills report no result
  typedef enum logic [1:0] {
    NO_RSP,
    HIT,
    MISS
  } t_lu_result;

  // Requests toward far memory
  typedef enum logic [1:0] {
    FM_NONE,
    FILL_REQ_OP,
    DIRTY_EVICT_OP
  } t_fm_op;

endpackage

`default_nettype wire

// ==== src/cache_param_pkg.sv ====
//==========================================================================
// Cache geometry
// Address field bounds, way and set counts and cache-line width
//==========================================================================
`default_nettype none

package cache_param_pkg;

  // Address and data widths
  localparam int ADDR_WIDTH      = 32;
  localparam int WORD_WIDTH      = 32;
  localparam int NUM_WORDS_IN_CL = 4;
  localparam int CL_WIDTH        = NUM_WORDS_IN_CL * WORD_WIDTH;

  // Four ways of sixteen sets
  localparam int NUM_WAYS  = 4;
  localparam int WAY_WIDTH = $clog2(NUM_WAYS);
  localparam int NUM_SETS  = 16;
  localparam int SET_WIDTH = $clog2(NUM_SETS);

  // Address split into tag, set and word offset
  // Byte bits [1:0] belong to no field
  localparam int OFFSET_WIDTH = $clog2(NUM_WORDS_IN_CL);
  localparam int LSB_OFFSET   = 2;
  localparam int MSB_OFFSET   = LSB_OFFSET + OFFSET_WIDTH - 1;
  localparam int LSB_SET      = MSB_OFFSET + 1;
  localparam int MSB_SET      = LSB_SET + SET_WIDTH - 1;
  localparam int LSB_TAG      = MSB_SET + 1;
  localparam int MSB_TAG      = ADDR_WIDTH - 1;
  localparam int TAG_WIDTH    = MSB_TAG - LSB_TAG + 1;

  // Data array index is {set, way}
  localparam int CL_ADDR_WIDTH = SET_WIDTH + WAY_WIDTH;

  // Transaction queue entry id
  localparam int TQ_ID_WIDTH = 4;

endpackage

`default_nettype wire
